//--- design/frame_bus_pkg.sv
package frame_bus_pkg;

	// Camera and display word width
	localparam int pixel_w = 32;

	// One pixel word
	// Same format on the camera bus, in memory and on the video output
	typedef logic [pixel_w-1:0] pixel_t;

	// Write side frame detector
	typedef enum logic [1:0] {
		// Wait for frame_valid to rise
		wr_idle      = 2'd0,
		// Frame started, wait for first pixel_valid rise
		wr_wait_dval = 2'd1,
		// wr_new_frame is high in this state
		wr_pulse     = 2'd2
	} wr_sync_state_t;

	// Read side frame detector
	typedef enum logic [1:0] {
		// Wait for raw_de rise at the first active pixel
		rd_idle      = 2'd0,
		// rd_new_frame is high in this state
		rd_pulse     = 2'd1,
		// Ignore later line starts until the frame is read out
		rd_wait_done = 2'd2
	} rd_sync_state_t;

	// A 32x20 frame fits 640 words of memory
	// The address counters carry one spare bit so they can hold frame_size
	// Pixels arriving past that point are discarded

endpackage

//--- design/write_frame_sync.sv
`timescale 1ns/1ps

module write_frame_sync
	import frame_bus_pkg::*;
#(
	parameter int start_threshold = 512
) (
	input  logic GPIO1_PIXLCLK,
	input  logic reset_n,
	input  logic pixel_valid,
	input  logic frame_valid,
	output logic wr_new_frame,
	output logic read_enable
);

	// Threshold in counter width
	localparam logic [15:0] cnt_start = 16'(start_threshold);

	logic [15:0]    pixel_cnt;
	logic           pre_frame_valid;
	logic           pre_pixel_valid;
	wr_sync_state_t wr_state;

	// Start-up pixel count
	// Saturates so it never wraps back through the threshold
	always_ff @(posedge GPIO1_PIXLCLK) begin
		if (!reset_n) begin
			pixel_cnt <= '0;
		end else if (pixel_valid && (pixel_cnt != 16'hffff)) begin
			pixel_cnt <= pixel_cnt + 16'd1;
		end
	end

	// Display gate, sticky until reset
	// Keeps the raster off until memory holds real pixels
	always_ff @(posedge GPIO1_PIXLCLK) begin
		if (!reset_n) begin
			read_enable <= 1'b0;
		end else if (pixel_cnt == cnt_start) begin
			read_enable <= 1'b1;
		end
	end

	// New frame detector
	// One pulse at the first valid pixel after frame_valid rises
	always_ff @(posedge GPIO1_PIXLCLK) begin
		if (!reset_n) begin
			wr_state        <= wr_idle;
			wr_new_frame    <= 1'b0;
			pre_frame_valid <= 1'b0;
			pre_pixel_valid <= 1'b0;
		end else begin
			pre_frame_valid <= frame_valid;
			pre_pixel_valid <= pixel_valid;
			case (wr_state)
				wr_idle: begin
					// Frame start edge
					if (!pre_frame_valid && frame_valid) begin
						wr_state <= wr_wait_dval;
					end
				end
				wr_wait_dval: begin
					// First pixel of the frame, pulse lines up with the
					// buffer's registered copy of this pixel
					if (!pre_pixel_valid && pixel_valid) begin
						wr_new_frame <= 1'b1;
						wr_state     <= wr_pulse;
					end
				end
				wr_pulse: begin
					wr_new_frame <= 1'b0;
					wr_state     <= wr_idle;
				end
				default: begin
					wr_new_frame <= 1'b0;
					wr_state     <= wr_idle;
				end
			endcase
		end
	end

endmodule

//--- design/read_frame_sync.sv
`timescale 1ns/1ps

module read_frame_sync
	import frame_bus_pkg::*;
(
	input  logic GPIO1_PIXLCLK,
	input  logic reset_n,
	input  logic raw_de,
	input  logic frame_read_done,
	output logic rd_new_frame
);

	logic           pre_raw_de;
	rd_sync_state_t rd_state;

	// Read address resync
	// Pulse once per displayed frame, on its first active pixel
	always_ff @(posedge GPIO1_PIXLCLK) begin
		if (!reset_n) begin
			rd_state     <= rd_idle;
			rd_new_frame <= 1'b0;
			pre_raw_de   <= 1'b0;
		end else begin
			pre_raw_de <= raw_de;
			case (rd_state)
				rd_idle: begin
					// First de rise after arming is the frame's first line
					if (!pre_raw_de && raw_de) begin
						rd_new_frame <= 1'b1;
						rd_state     <= rd_pulse;
					end
				end
				rd_pulse: begin
					rd_new_frame <= 1'b0;
					rd_state     <= rd_wait_done;
				end
				rd_wait_done: begin
					// Later line starts land here and are ignored
					// Buffer signals the last word of the frame
					if (frame_read_done) begin
						rd_state <= rd_idle;
					end
				end
				default: begin
					rd_new_frame <= 1'b0;
					rd_state     <= rd_idle;
				end
			endcase
		end
	end

	// Done strobe arrives in horizontal blank after the last line,
	// so the next de rise is the next frame's first line

endmodule

//--- design/frame_buffer.sv
`timescale 1ns/1ps

module frame_buffer
	import frame_bus_pkg::*;
#(
	parameter int frame_size = 640
) (
	input  logic   GPIO1_PIXLCLK,
	input  logic   reset_n,
	input  pixel_t pixel_data,
	input  logic   pixel_valid,
	input  logic   wr_new_frame,
	input  logic   raw_de,
	input  logic   rd_new_frame,
	output pixel_t rd_data,
	output logic   frame_read_done
);

	// One spare count so the write address can park at frame_size
	localparam int addr_w = $clog2(frame_size + 1);

	localparam logic [addr_w-1:0] addr_one  = addr_w'(1);
	localparam logic [addr_w-1:0] frame_end = addr_w'(frame_size);
	localparam logic [addr_w-1:0] rd_last   = addr_w'(frame_size - 1);

	// Frame memory with one write port and one read port
	pixel_t mem [frame_size];

	// Input register stage
	pixel_t r_pixel;
	logic   r_valid;

	// Write side
	logic [addr_w-1:0] wr_addr;
	logic [addr_w-1:0] wr_index;
	logic              wr_en;

	// Read side
	logic [addr_w-1:0] rd_addr;
	logic [addr_w-1:0] rd_index;
	logic              rd_wrap;

	// Camera word registered once
	always_ff @(posedge GPIO1_PIXLCLK) begin
		r_pixel <= pixel_data;
	end

	// New frame restarts at word zero
	// Past the end of the frame nothing is stored
	assign wr_index = wr_new_frame ? '0 : wr_addr;
	assign wr_en    = r_valid && (wr_new_frame || (wr_addr != frame_end));

	always_ff @(posedge GPIO1_PIXLCLK) begin
		if (!reset_n) begin
			r_valid <= 1'b0;
			wr_addr <= '0;
		end else begin
			r_valid <= pixel_valid;
			if (wr_new_frame) begin
				// Word zero is written now when the pixel is valid
				wr_addr <= r_valid ? addr_one : '0;
			end else if (wr_en) begin
				wr_addr <= wr_addr + addr_one;
			end
		end
	end

	// Memory write
	always_ff @(posedge GPIO1_PIXLCLK) begin
		if (wr_en) begin
			mem[wr_index] <= r_pixel;
		end
	end

	// Resync cycle reads word one
	// Word zero went out on the cycle before
	assign rd_index = rd_new_frame ? addr_one : rd_addr;
	assign rd_wrap  = (rd_index == rd_last);

	// Registered read
	// Same address as a write on this edge gives the old word
	always_ff @(posedge GPIO1_PIXLCLK) begin
		if (raw_de) begin
			rd_data <= mem[rd_index];
		end
	end

	// Read address and end of frame strobe
	always_ff @(posedge GPIO1_PIXLCLK) begin
		if (!reset_n) begin
			rd_addr         <= '0;
			frame_read_done <= 1'b0;
		end else begin
			frame_read_done <= 1'b0;
			if (raw_de) begin
				if (rd_wrap) begin
					// Last word of the frame
					rd_addr         <= '0;
					frame_read_done <= 1'b1;
				end else begin
					rd_addr <= rd_index + addr_one;
				end
			end else if (rd_new_frame) begin
				rd_addr <= addr_one;
			end
		end
	end

	// No back-pressure toward the camera
	// A later frame just overwrites memory from word zero

endmodule

//--- design/video_timing_gen.sv
`timescale 1ns/1ps

module video_timing_gen #(
	parameter int h_active = 32,
	parameter int h_blank  = 8,
	parameter int v_active = 20,
	parameter int v_blank  = 4,
	parameter int hs_width = 4,
	parameter int vs_width = 2
) (
	input  logic GPIO1_PIXLCLK,
	input  logic reset_n,
	input  logic read_enable,
	output logic raw_de,
	output logic video_de,
	output logic video_hs,
	output logic video_vs
);

	localparam int h_total = h_active + h_blank;
	localparam int v_total = v_active + v_blank;
	localparam int col_w   = $clog2(h_total);
	localparam int line_w  = $clog2(v_total);

	localparam logic [col_w-1:0]  col_last  = col_w'(h_total - 1);
	localparam logic [line_w-1:0] line_last = line_w'(v_total - 1);

	logic [col_w-1:0]  col_cnt;
	logic [line_w-1:0] line_cnt;
	logic              raw_hs;
	logic              raw_vs;

	// Raster counters
	// Parked at zero until the write side has filled enough memory
	always_ff @(posedge GPIO1_PIXLCLK) begin
		if (!reset_n || !read_enable) begin
			col_cnt  <= '0;
			line_cnt <= '0;
		end else if (col_cnt == col_last) begin
			col_cnt <= '0;
			// End of line
			if (line_cnt == line_last) begin
				line_cnt <= '0;
			end else begin
				line_cnt <= line_cnt + 1'b1;
			end
		end else begin
			col_cnt <= col_cnt + 1'b1;
		end
	end

	// Decode from the counters
	// raw_de feeds the buffer's read port directly
	always_ff @(posedge GPIO1_PIXLCLK) begin
		if (!reset_n || !read_enable) begin
			raw_de <= 1'b0;
			raw_hs <= 1'b0;
			raw_vs <= 1'b0;
		end else begin
			raw_de <= (col_cnt < h_active) && (line_cnt < v_active);
			// Sync starts at the first blank column
			raw_hs <= (col_cnt >= h_active) && (col_cnt < h_active + hs_width);
			// Whole lines at the start of vertical blank
			raw_vs <= (line_cnt >= v_active) && (line_cnt < v_active + vs_width);
		end
	end

	// One more stage to line up with the registered read data
	always_ff @(posedge GPIO1_PIXLCLK) begin
		if (!reset_n) begin
			video_de <= 1'b0;
			video_hs <= 1'b0;
			video_vs <= 1'b0;
		end else begin
			video_de <= raw_de;
			video_hs <= raw_hs;
			video_vs <= raw_vs;
		end
	end

endmodule

//--- design/frame_bus.sv
`timescale 1ns/1ps

module frame_bus
	import frame_bus_pkg::*;
#(
	parameter int h_active        = 32,
	parameter int v_active        = 20,
	parameter int h_blank         = 8,
	parameter int v_blank         = 4,
	parameter int hs_width        = 4,
	parameter int vs_width        = 2,
	parameter int start_threshold = 512
) (
	input  logic   GPIO1_PIXLCLK,
	input  logic   reset_n,
	input  pixel_t pixel_data,
	input  logic   pixel_valid,
	input  logic   frame_valid,
	output pixel_t video_data,
	output logic   video_de,
	output logic   video_hs,
	output logic   video_vs
);

	// Memory holds exactly one displayed frame
	localparam int frame_size = h_active * v_active;

	logic wr_new_frame;
	logic read_enable;
	logic raw_de;
	logic rd_new_frame;
	logic frame_read_done;

	// Camera frame start and display start-up gate
	write_frame_sync #(
		.start_threshold(start_threshold)
	) u_write_frame_sync (
		.GPIO1_PIXLCLK(GPIO1_PIXLCLK),
		.reset_n      (reset_n),
		.pixel_valid  (pixel_valid),
		.frame_valid  (frame_valid),
		.wr_new_frame (wr_new_frame),
		.read_enable  (read_enable)
	);

	// On-chip frame memory
	// Read data goes straight out as the video word
	frame_buffer #(
		.frame_size(frame_size)
	) u_frame_buffer (
		.GPIO1_PIXLCLK  (GPIO1_PIXLCLK),
		.reset_n        (reset_n),
		.pixel_data     (pixel_data),
		.pixel_valid    (pixel_valid),
		.wr_new_frame   (wr_new_frame),
		.raw_de         (raw_de),
		.rd_new_frame   (rd_new_frame),
		.rd_data        (video_data),
		.frame_read_done(frame_read_done)
	);

	// Display frame start
	read_frame_sync u_read_frame_sync (
		.GPIO1_PIXLCLK  (GPIO1_PIXLCLK),
		.reset_n        (reset_n),
		.raw_de         (raw_de),
		.frame_read_done(frame_read_done),
		.rd_new_frame   (rd_new_frame)
	);

	// Raster timing
	video_timing_gen #(
		.h_active(h_active),
		.h_blank (h_blank),
		.v_active(v_active),
		.v_blank (v_blank),
		.hs_width(hs_width),
		.vs_width(vs_width)
	) u_video_timing_gen (
		.GPIO1_PIXLCLK(GPIO1_PIXLCLK),
		.reset_n      (reset_n),
		.read_enable  (read_enable),
		.raw_de       (raw_de),
		.video_de     (video_de),
		.video_hs     (video_hs),
		.video_vs     (video_vs)
	);

endmodule

//--- tb/tb_frame_bus.sv
`timescale 1ns/1ps

module tb_frame_bus
	import frame_bus_pkg::*;
;

	// Same raster as the DUT is built with
	localparam int h_active        = 32;
	localparam int v_active        = 20;
	localparam int h_blank         = 8;
	localparam int v_blank         = 4;
	localparam int hs_width        = 4;
	localparam int vs_width        = 2;
	localparam int start_threshold = 512;
	localparam int frame_size      = h_active * v_active;
	localparam int h_total         = h_active + h_blank;
	localparam int v_total         = v_active + v_blank;

	logic   GPIO1_PIXLCLK;
	logic   reset_n;
	pixel_t pixel_data;
	logic   pixel_valid;
	logic   frame_valid;
	pixel_t video_data;
	logic   video_de;
	logic   video_hs;
	logic   video_vs;

	logic [31:0] lcg_state;

	// Memory model and its write pointer
	pixel_t model_mem [frame_size];
	int     model_wr_addr;
	// Pixel sampled one edge ago, lands in memory on the next edge
	logic   pend_valid;
	logic   pend_first;
	pixel_t pend_data;
	// Marks the first pixel of a frame while it sits on the bus
	logic   drv_first;
	int     sampled_cnt;

	// Raster model, starts at the first video_de
	logic started;
	int   col;
	int   line;
	int   model_rd_addr;
	int   frames_shown;

	int   data_errors;
	int   ctl_errors;
	int   other_errors;
	logic timed_out;
	int   f;

	frame_bus #(
		.h_active       (h_active),
		.v_active       (v_active),
		.h_blank        (h_blank),
		.v_blank        (v_blank),
		.hs_width       (hs_width),
		.vs_width       (vs_width),
		.start_threshold(start_threshold)
	) u_frame_bus (
		.GPIO1_PIXLCLK(GPIO1_PIXLCLK),
		.reset_n      (reset_n),
		.pixel_data   (pixel_data),
		.pixel_valid  (pixel_valid),
		.frame_valid  (frame_valid),
		.video_data   (video_data),
		.video_de     (video_de),
		.video_hs     (video_hs),
		.video_vs     (video_vs)
	);

	// 8 ns pixel clock
	always begin
		#4;
		GPIO1_PIXLCLK = ~GPIO1_PIXLCLK;
	end

	function automatic logic [31:0] rand_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// Upper LCG bits, low bits cycle too fast
	function automatic int rand_below(int n);
		logic [31:0] r;
		r = rand_next();
		return int'(r[31:16]) % n;
	endfunction

	// Full frames carry up to 40 extra pixels that must be dropped
	function automatic int pick_length(int frame_no);
		// First frame fills the memory before the display reads it
		if (frame_no == 0 || rand_below(2) == 0) begin
			return frame_size + rand_below(41);
		end
		return frame_size / 2 + rand_below(frame_size / 2);
	endfunction

	task automatic check_pixel(string name, pixel_t got, pixel_t exp);
		if (got !== exp) begin
			data_errors++;
			$display("Error: %s got %h expected %h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic check_bit(string name, bit got, bit exp);
		if (got != exp) begin
			ctl_errors++;
			$display("Error: %s got %h expected %h at %0t", name, got, exp, $time);
		end
	endtask

	// Model of the edge just passed, outputs are stable here
	task automatic model_edge();
		int idx;
		bit exp_de;
		bit exp_hs;
		bit exp_vs;
		if (!started) begin
			if (video_de) begin
				started       = 1'b1;
				col           = 0;
				line          = 0;
				model_rd_addr = 0;
				if (sampled_cnt < start_threshold) begin
					other_errors++;
					$display("Display started after only %0d camera pixels", sampled_cnt);
				end
			end else begin
				check_bit("video_hs", video_hs, 1'b0);
				check_bit("video_vs", video_vs, 1'b0);
			end
		end
		if (started) begin
			exp_de = (col < h_active) && (line < v_active);
			exp_hs = (col >= h_active) && (col < h_active + hs_width);
			exp_vs = (line >= v_active) && (line < v_active + vs_width);
			check_bit("video_de", video_de, exp_de);
			check_bit("video_hs", video_hs, exp_hs);
			check_bit("video_vs", video_vs, exp_vs);
			if (exp_de) begin
				// Second pixel of a frame resyncs the pointer to word one
				idx = (line == 0 && col == 1) ? 1 : model_rd_addr;
				// Memory as it stood before this edge's write
				check_pixel("video_data", video_data, model_mem[idx]);
				model_rd_addr = (idx == frame_size - 1) ? 0 : idx + 1;
			end
			if (col == h_total - 1) begin
				col = 0;
				if (line == v_total - 1) begin
					line = 0;
					frames_shown++;
				end else begin
					line++;
				end
			end else begin
				col++;
			end
		end
		// Write of the pixel sampled one edge earlier
		if (pend_valid) begin
			if (pend_first) begin
				model_wr_addr = 0;
			end
			// Past frame_size nothing is stored
			if (model_wr_addr < frame_size) begin
				model_mem[model_wr_addr] = pend_data;
				model_wr_addr++;
			end
		end
		pend_valid = pixel_valid;
		pend_first = drv_first;
		pend_data  = pixel_data;
		if (pixel_valid) begin
			sampled_cnt++;
		end
	endtask

	// One clock, then new inputs on the falling edge
	task automatic clock_cycle(logic fv, logic pv, logic first);
		@(negedge GPIO1_PIXLCLK);
		model_edge();
		frame_valid = fv;
		pixel_valid = pv;
		drv_first   = first;
		// Random word even when idle, must never be stored
		pixel_data  = rand_next();
	endtask

	task automatic send_frame(int n_pixels);
		int i;
		int gap;
		// frame_valid rises with the bus idle, first pixel follows
		repeat (2) clock_cycle(1'b1, 1'b0, 1'b0);
		for (i = 0; i < n_pixels; i++) begin
			// Short line blank every h_active pixels
			if (i != 0 && i % h_active == 0) begin
				repeat (h_blank / 2) clock_cycle(1'b1, 1'b0, 1'b0);
			end
			// random stall inside the line
			if (rand_below(4) == 0) begin
				gap = 1 + rand_below(3);
				repeat (gap) clock_cycle(1'b1, 1'b0, 1'b0);
			end
			clock_cycle(1'b1, 1'b1, i == 0);
		end
		gap = 2 + rand_below(4);
		repeat (gap) clock_cycle(1'b0, 1'b0, 1'b0);
	endtask

	task automatic wait_display_start(int max_cycles);
		int             n;
		wr_sync_state_t wr_st;
		n = 0;
		while (!started && n < max_cycles) begin
			clock_cycle(1'b0, 1'b0, 1'b0);
			n++;
		end
		if (!started) begin
			wr_st = u_frame_bus.u_write_frame_sync.wr_state;
			other_errors++;
			timed_out = 1'b1;
			$display("Timeout: no video_de within %0d cycles, write detector in %s",
				max_cycles, wr_st.name());
		end
	endtask

	task automatic wait_frames(int count, int max_cycles);
		int n;
		int target;
		n      = 0;
		target = frames_shown + count;
		while (frames_shown < target && n < max_cycles) begin
			clock_cycle(1'b0, 1'b0, 1'b0);
			n++;
		end
		if (frames_shown < target) begin
			other_errors++;
			timed_out = 1'b1;
			$display("Timeout: %0d displayed frames did not finish in %0d cycles",
				count, max_cycles);
		end
	endtask

	initial begin
		GPIO1_PIXLCLK = 1'b0;
		reset_n       = 1'b0;
		pixel_data    = '0;
		pixel_valid   = 1'b0;
		frame_valid   = 1'b0;
		lcg_state     = 32'h7440;
		drv_first     = 1'b0;
		pend_valid    = 1'b0;
		pend_first    = 1'b0;
		pend_data     = '0;
		model_wr_addr = 0;
		sampled_cnt   = 0;
		started       = 1'b0;
		col           = 0;
		line          = 0;
		model_rd_addr = 0;
		frames_shown  = 0;
		data_errors   = 0;
		ctl_errors    = 0;
		other_errors  = 0;
		timed_out     = 1'b0;
		// 4 rising edges in reset
		repeat (4) @(negedge GPIO1_PIXLCLK);
		reset_n = 1'b1;
		send_frame(pick_length(0));
		wait_display_start(4 * h_total);
		// Later frames overwrite from word zero, some short
		for (f = 1; f < 6 && !timed_out; f++) begin
			send_frame(pick_length(f));
		end
		if (!timed_out) begin
			wait_frames(2, 3 * h_total * v_total);
		end
		$display("Summary: %0d data errors, %0d control errors, %0d other errors",
			data_errors, ctl_errors, other_errors);
		if (data_errors + ctl_errors + other_errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

//--- all.f
design/frame_bus_pkg.sv
design/write_frame_sync.sv
design/read_frame_sync.sv
design/frame_buffer.sv
design/video_timing_gen.sv
design/frame_bus.sv
tb/tb_frame_bus.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the frame_bus testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing -Wno-fatal -f all.f --top-module tb_frame_bus -o tb_frame_bus
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

./obj_dir/tb_frame_bus > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

# Pass only if the testbench printed its pass line
if grep -q "^Regression passed$" "$log"; then
	exit 0
fi
echo "Pass line not found in $log"
exit 1
